//--- filelist.f
+incdir+common
common/rv_pkg.sv
design/regfile.sv
decode/rv_decoder.sv
decode/issue_stage.sv
execute/alu_stage.sv
design/retire_stage.sv
design/rv_exec_top.sv
sim/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - design/regfile.sv
      - decode/rv_decoder.sv
      - decode/issue_stage.sv
      - execute/alu_stage.sv
      - design/retire_stage.sv
      - design/rv_exec_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/rv_exec_tb.sv

//--- sim/rv_exec_tb.sv
`include "rv_consts.svh"

module rv_exec_tb import rv_pkg::*; ();

	localparam int M_NONE  = 0;   // nothing may retire
	localparam int M_ILL   = 1;   // illegal flag, no valid
	localparam int M_FLAGS = 2;   // valid, flags, dest and target only
	localparam int M_FULL  = 3;

	logic        clock, rst, halted;
	fetch_pkt_t  fetch;
	retire_pkt_t retire;

	word_t       regs [`NUM_REGS];   // architectural model in program order
	retire_pkt_t exp_q [$];
	int          mode_q [$];
	integer      seed;
	int          checks, test_errs, total_errs, n_issued;
	logic        model_halted;
	addr_t       pc;

	rv_exec_top i_dut (
		.clock  (clock),
		.rst    (rst),
		.fetch  (fetch),
		.retire (retire),
		.halted (halted)
	);

	always #2 clock = ~clock;

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("CHECK FAILED @%0t: %s", $time, msg);
			test_errs++;
		end
	endtask

	function automatic word_t ref_alu(input alu_func_e f, input word_t a, input word_t b);
		longint ss, su, uu;
		ss = longint'($signed(a)) * longint'($signed(b));
		su = longint'($signed(a)) * longint'({32'b0, b});
		uu = longint'({32'b0, a}) * longint'({32'b0, b});
		case (f)
			SUB:     return a - b;
			SLT:     return {31'b0, $signed(a) < $signed(b)};
			SLTU:    return {31'b0, a < b};
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLL:     return a << b[4:0];
			SRL:     return a >> b[4:0];
			SRA:     return word_t'($signed(a) >>> b[4:0]);
			MUL:     return uu[31:0];
			MULH:    return ss[63:32];
			MULHSU:  return su[63:32];
			MULHU:   return uu[63:32];
			default: return a + b;
		endcase
	endfunction

	task automatic compare_retire(input retire_pkt_t e, input int mode);
		if (mode == M_NONE) begin
			check(retire.valid === 1'b0 && i_dut.wr_en === 1'b0, "retire or write with nothing due");
		end else if (mode == M_ILL) begin
			check(!retire.valid && retire.illegal && !i_dut.wr_en, "illegal op not flagged or it wrote");
		end else begin
			check(retire.valid === 1'b1, "retire.valid missing three edges after fetch");
			check(retire.dest === e.dest && i_dut.wr_en === (e.dest != 0),
				$sformatf("dest %0d wr_en %b, expected dest %0d", retire.dest, i_dut.wr_en, e.dest));
			// low seven bits hold the flags, cond_branch down to illegal
			check(retire[6:0] === e[6:0], $sformatf("flags %b, expected %b", retire[6:0], e[6:0]));
			check(retire.target === e.target,
				$sformatf("target %h, expected %h", retire.target, e.target));
			if (mode == M_FULL)
				check(retire.result === e.result,
					$sformatf("result %h, expected %h", retire.result, e.result));
			if (e.halt)
				check(halted === 1'b1, "halted did not rise with the WFI");
		end
	endtask

	// one fetch slot; the slot from three edges back is on retire now
	task automatic step(input logic v, input logic [31:0] raw, input retire_pkt_t e, input int mode);
		@(negedge clock);
		if (exp_q.size() == 3)
			compare_retire(exp_q.pop_front(), mode_q.pop_front());
		fetch.valid = v;
		fetch.inst  = raw;
		fetch.pc    = pc;
		exp_q.push_back(e);
		mode_q.push_back(model_halted ? M_NONE : mode);
		n_issued++;
		pc += 4;
	endtask

	task automatic drain();
		repeat (3) step(1'b0, '0, '0, M_NONE);
	endtask

	task automatic commit(input reg_idx_t rd, input word_t val);
		if (!model_halted && rd != 0)
			regs[rd] = val;
	endtask

	task automatic alu_op(input logic [31:0] raw, input alu_func_e f, input reg_idx_t rd,
		input word_t a, input word_t b);
		retire_pkt_t e;
		e        = '0;
		e.valid  = 1'b1;
		e.dest   = rd;
		e.result = ref_alu(f, a, b);
		commit(rd, e.result);
		step(1'b1, raw, e, M_FULL);
	endtask

	task automatic jump_op(input logic [31:0] raw, input reg_idx_t rd, input addr_t target);
		retire_pkt_t e;
		e               = '0;
		e.valid         = 1'b1;
		e.dest          = rd;
		e.result        = pc + 4;   // link
		e.target        = target;
		e.uncond_branch = 1'b1;
		commit(rd, e.result);
		step(1'b1, raw, e, M_FULL);
	endtask

	task automatic op_imm(input logic [2:0] f3, input alu_func_e f, input reg_idx_t rd,
		input reg_idx_t rs1, input logic [11:0] imm);
		alu_op({imm, rs1, f3, rd, 7'b0010011}, f, rd, regs[rs1], {{20{imm[11]}}, imm});
	endtask

	task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input alu_func_e f,
		input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		alu_op({f7, rs2, rs1, f3, rd, 7'b0110011}, f, rd, regs[rs1], regs[rs2]);
	endtask

	task automatic op_lui(input reg_idx_t rd, input logic [19:0] u);
		alu_op({u, rd, 7'b0110111}, ADD, rd, '0, {u, 12'b0});
	endtask

	task automatic load_word(input reg_idx_t rd);
		op_lui(rd, $random(seed));
		op_imm(3'b000, ADD, rd, rd, $random(seed));
	endtask

	task automatic apply_reset();
		rst         = 1'b1;
		fetch.valid = 1'b0;
		repeat (2) @(negedge clock);
		rst = 1'b0;
		check(!halted && !retire.valid, "reset left halted or retire.valid high");
		exp_q.delete();
		mode_q.delete();
		model_halted = 1'b0;
		drain();
	endtask

	task automatic end_test(input string name);
		drain();
		$display("%-10s %s, %0d errors", name, (test_errs == 0) ? "ok" : "mismatch", test_errs);
		total_errs += test_errs;
		test_errs = 0;
	endtask

	task automatic imm_test();
		for (int r = 1; r <= 8; r++)
			op_imm(3'b000, ADD, r, 0, $random(seed));
		for (int k = 1; k <= 8; k++) begin
			op_imm(3'b010, SLT, 9, k, $random(seed));
			op_imm(3'b011, SLTU, 10, k, $random(seed));
			op_imm(3'b111, AND, 11, k, $random(seed));
			op_imm(3'b110, OR, 12, k, $random(seed));
			op_imm(3'b100, XOR, 13, 12, $random(seed));   // reads the ORI just before
			op_imm(3'b001, SLL, 14, k, {7'b0, 5'($random(seed))});
			op_imm(3'b101, SRL, 15, 14, {7'b0, 5'($random(seed))});
			op_imm(3'b101, SRA, 16, k, {7'b0100000, 5'($random(seed))});
		end
		end_test("imm");
	endtask

	task automatic reg_test();
		alu_func_e  funcs [14] = '{ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA,
			MUL, MULH, MULHSU, MULHU};
		logic [9:0] codes [14] = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd2}, {7'h00, 3'd3},
			{7'h00, 3'd7}, {7'h00, 3'd6}, {7'h00, 3'd4}, {7'h00, 3'd1}, {7'h00, 3'd5},
			{7'h20, 3'd5}, {7'h01, 3'd0}, {7'h01, 3'd1}, {7'h01, 3'd2}, {7'h01, 3'd3}};
		// rs2 producer sits d slots back, rs1 producer d+2
		for (int d = 1; d <= 3; d++) begin
			for (int k = 0; k < 14; k++) begin
				load_word(20);
				load_word(21);
				for (int f = 1; f < d; f++)
					op_imm(3'b000, ADD, 24, 0, $random(seed));
				op_reg(codes[k][9:3], codes[k][2:0], funcs[k], 22, 20, 21);
			end
		end
		end_test("reg");
	endtask

	task automatic jump_test();
		logic [19:0] u;
		logic [20:0] off;
		logic [11:0] imm;
		u = $random(seed);
		op_lui(27, u);
		alu_op({u, 5'd28, 7'b0010111}, ADD, 28, pc, {u, 12'b0});   // auipc
		off    = $random(seed);
		off[0] = 1'b0;
		jump_op({off[20], off[10:1], off[11], off[19:12], 5'd29, 7'b1101111}, 29,
			pc + {{11{off[20]}}, off});
		imm = $random(seed);
		jump_op({imm, 5'd27, 3'b000, 5'd30, 7'b1100111}, 30,
			(regs[27] + {{20{imm[11]}}, imm}) & ~32'd1);
		jump_op({imm, 5'd30, 3'b000, 5'd31, 7'b1100111}, 31,
			(regs[30] + {{20{imm[11]}}, imm}) & ~32'd1);
		jump_op({off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111}, 0,
			pc + {{11{off[20]}}, off});
		op_imm(3'b000, ADD, 0, 27, $random(seed));
		op_reg(7'h00, 3'd0, ADD, 25, 0, 0);   // x0 must still read zero
		end_test("jump");
	endtask

	task automatic flag_test();
		retire_pkt_t e;
		op_imm(3'b000, ADD, 5, 0, $random(seed));
		e             = '0;
		e.valid       = 1'b1;
		e.cond_branch = 1'b1;
		step(1'b1, {7'h00, 5'd2, 5'd1, 3'b000, 5'd5, 7'b1100011}, e, M_FLAGS);
		e.cond_branch = 1'b0;
		e.rd_mem      = 1'b1;
		step(1'b1, {12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011}, e, M_FLAGS);
		e.rd_mem = 1'b0;
		e.wr_mem = 1'b1;
		step(1'b1, {7'h00, 5'd2, 5'd1, 3'b010, 5'd5, 7'b0100011}, e, M_FLAGS);
		e.wr_mem = 1'b0;
		e.csr_op = 1'b1;
		step(1'b1, {12'h300, 5'd1, 3'b001, 5'd5, 7'b1110011}, e, M_FLAGS);
		op_reg(7'h00, 3'd0, ADD, 26, 5, 0);   // old x5 expected
		end_test("flags");
	endtask

	task automatic illegal_test();
		retire_pkt_t e;
		e         = '0;
		e.illegal = 1'b1;
		op_imm(3'b000, ADD, 5, 0, $random(seed));
		step(1'b1, 32'hffff_ffff, e, M_ILL);
		step(1'b1, {7'b0100000, 5'd1, 5'd5, 3'b001, 5'd5, 7'b0010011}, e, M_ILL);
		step(1'b0, {12'd7, 5'd0, 3'b000, 5'd5, 7'b0010011}, '0, M_NONE);   // idle slot
		op_reg(7'h00, 3'd0, ADD, 26, 5, 0);
		end_test("illegal");
	endtask

	task automatic halt_test();
		retire_pkt_t e;
		e       = '0;
		e.valid = 1'b1;
		e.halt  = 1'b1;
		step(1'b1, `WFI, e, M_FLAGS);
		model_halted = 1'b1;
		op_imm(3'b000, ADD, 5, 0, 12'h123);
		op_reg(7'h00, 3'd0, ADD, 6, 1, 2);
		drain();
		check(halted === 1'b1, "halted dropped after the WFI");
		apply_reset();
		for (int r = 1; r < `NUM_REGS; r++)
			op_reg(7'h00, 3'd0, ADD, 0, r, 0);   // probe without writing
		end_test("halt");
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= n_issued * 40 + 200) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run went past %0d cycles for %0d issued slots", cycles, n_issued);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		clock        = 1'b0;
		rst          = 1'b1;
		fetch        = '0;
		seed         = 32'h12d2;
		pc           = 32'h0000_1000;
		model_halted = 1'b0;
		checks       = 0;
		test_errs    = 0;
		total_errs   = 0;
		n_issued     = 0;
		for (int r = 0; r < `NUM_REGS; r++)
			regs[r] = '0;
		apply_reset();
		imm_test();
		reg_test();
		jump_test();
		flag_test();
		illegal_test();
		halt_test();
		$display("done: %0d checks, %0d errors", checks, total_errs);
		if (total_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- design/rv_exec_top.sv
module rv_exec_top import rv_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  fetch_pkt_t  fetch,
	output retire_pkt_t retire,
	output logic        halted
);

	ctrl_t      ctrl;
	reg_idx_t   rs1_idx, rs2_idx;
	word_t      rs1_data, rs2_data;
	issue_pkt_t issue;
	exec_pkt_t  exec;
	logic       wr_en;
	reg_idx_t   wr_idx;
	word_t      wr_data;

	rv_decoder i_decoder (.*);

	issue_stage i_issue (.*);

	regfile i_regfile (
		.clock   (clock),
		.rda_idx (rs1_idx),
		.rdb_idx (rs2_idx),
		.rda_out (rs1_data),
		.rdb_out (rs2_data),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data)
	);

	alu_stage i_alu (
		.clock   (clock),
		.rst     (rst),
		.issue   (issue),
		.ret_fwd (retire),   // retire register is the second bypass source
		.exec    (exec)
	);

	retire_stage i_retire (.*);

endmodule

//--- design/retire_stage.sv
`include "rv_consts.svh"

module retire_stage import rv_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  exec_pkt_t   exec,
	output retire_pkt_t retire,
	output logic        wr_en,
	output reg_idx_t    wr_idx,
	output word_t       wr_data,
	output logic        halted
);

	always_ff @(posedge clock) begin
		if (rst) begin
			retire.valid   <= `FALSE;
			retire.illegal <= `FALSE;
			halted         <= `FALSE;
		end else if (halted) begin
			retire.valid   <= `FALSE;   // nothing retires once stopped
		end else begin
			retire <= exec;
			halted <= exec.valid && exec.halt;
		end
	end

	assign wr_en   = retire.valid && !retire.illegal && retire.dest != `ZERO_REG;
	assign wr_idx  = retire.dest;
	assign wr_data = retire.result;

endmodule

//--- execute/alu_stage.sv
`include "rv_consts.svh"

module alu_stage import rv_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  issue_pkt_t  issue,
	input  retire_pkt_t ret_fwd,
	output exec_pkt_t   exec
);

	word_t               rs1, rs2;
	word_t               opa, opb;
	word_t               alu_res;
	addr_t               link;
	logic [2*`XLEN-1:0]  mul_a, mul_b, prod;
	exec_pkt_t           exec_nxt;

	// does an older result write the register we read
	function automatic logic fwd_hit(input exec_pkt_t src, input reg_idx_t idx);
		return src.valid && !src.illegal && src.dest != `ZERO_REG && src.dest == idx;
	endfunction

	assign rs1 = fwd_hit(exec, issue.rs1_idx)    ? exec.result :
		fwd_hit(ret_fwd, issue.rs1_idx) ? ret_fwd.result : issue.rs1_val;
	assign rs2 = fwd_hit(exec, issue.rs2_idx)    ? exec.result :
		fwd_hit(ret_fwd, issue.rs2_idx) ? ret_fwd.result : issue.rs2_val;

	always_comb begin
		case (issue.ctrl.opa_sel)
			OPA_IS_PC:   opa = issue.pc;
			OPA_IS_ZERO: opa = '0;
			default:     opa = rs1;
		endcase
		opb = (issue.ctrl.opb_sel == OPB_IS_RS2) ? rs2 : issue.imm;
	end

	// one 64 bit multiplier, operands extended per variant
	assign mul_a = (issue.ctrl.alu_func == MULH || issue.ctrl.alu_func == MULHSU) ?
		{{`XLEN{opa[`XLEN-1]}}, opa} : {{`XLEN{1'b0}}, opa};
	assign mul_b = (issue.ctrl.alu_func == MULH) ?
		{{`XLEN{opb[`XLEN-1]}}, opb} : {{`XLEN{1'b0}}, opb};
	assign prod  = mul_a * mul_b;

	always_comb begin
		case (issue.ctrl.alu_func)
			SUB:                  alu_res = opa - opb;
			SLT:                  alu_res = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			SLTU:                 alu_res = {{(`XLEN-1){1'b0}}, opa < opb};
			AND:                  alu_res = opa & opb;
			OR:                   alu_res = opa | opb;
			XOR:                  alu_res = opa ^ opb;
			SLL:                  alu_res = opa << opb[4:0];
			SRL:                  alu_res = opa >> opb[4:0];
			SRA:                  alu_res = $signed(opa) >>> opb[4:0];
			MUL:                  alu_res = prod[`XLEN-1:0];
			MULH, MULHSU, MULHU:  alu_res = prod[2*`XLEN-1:`XLEN];
			default:              alu_res = opa + opb;
		endcase
	end

	assign link = issue.pc + 4;

	always_comb begin
		exec_nxt.valid         = issue.ctrl.valid;
		exec_nxt.dest          = issue.dest;
		exec_nxt.result        = issue.ctrl.uncond_branch ? link : alu_res;
		exec_nxt.target        = '0;
		if (issue.ctrl.uncond_branch) begin
			exec_nxt.target    = alu_res;
			if (issue.ctrl.opa_sel == OPA_IS_RS1)
				exec_nxt.target[0] = 1'b0;   // jalr
		end
		exec_nxt.cond_branch   = issue.ctrl.cond_branch;
		exec_nxt.uncond_branch = issue.ctrl.uncond_branch;
		exec_nxt.rd_mem        = issue.ctrl.rd_mem;
		exec_nxt.wr_mem        = issue.ctrl.wr_mem;
		exec_nxt.csr_op        = issue.ctrl.csr_op;
		exec_nxt.halt          = issue.ctrl.halt;
		exec_nxt.illegal       = issue.ctrl.illegal;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			exec.valid   <= `FALSE;
			exec.illegal <= `FALSE;
		end else begin
			exec <= exec_nxt;
		end
	end

	// decoder must never mark an issued op as both branch kinds
	assert property (@(posedge clock) disable iff (rst)
		issue.ctrl.valid |-> !(issue.ctrl.cond_branch && issue.ctrl.uncond_branch));

endmodule

//--- decode/issue_stage.sv
`include "rv_consts.svh"

module issue_stage import rv_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  fetch_pkt_t fetch,
	input  ctrl_t      ctrl,
	output reg_idx_t   rs1_idx,
	output reg_idx_t   rs2_idx,
	input  word_t      rs1_data,
	input  word_t      rs2_data,
	output issue_pkt_t issue
);

	inst_t      inst;
	word_t      imm;
	issue_pkt_t issue_nxt;

	assign inst    = fetch.inst;
	assign rs1_idx = inst.r.rs1;
	assign rs2_idx = inst.r.rs2;

	always_comb begin
		case (ctrl.opb_sel)
			OPB_IS_I_IMM: imm = {{20{inst.raw[31]}}, inst.raw[31:20]};
			OPB_IS_S_IMM: imm = {{20{inst.raw[31]}}, inst.raw[31:25], inst.raw[11:7]};
			OPB_IS_B_IMM: imm = {{19{inst.raw[31]}}, inst.raw[31], inst.raw[7],
				inst.raw[30:25], inst.raw[11:8], 1'b0};
			OPB_IS_U_IMM: imm = {inst.raw[31:12], 12'b0};
			OPB_IS_J_IMM: imm = {{11{inst.raw[31]}}, inst.raw[31], inst.raw[19:12],
				inst.raw[20], inst.raw[30:21], 1'b0};
			default:      imm = '0;   // register operand, no immediate
		endcase
	end

	always_comb begin
		issue_nxt.ctrl    = ctrl;
		issue_nxt.pc      = fetch.pc;
		issue_nxt.rs1_idx = rs1_idx;
		issue_nxt.rs2_idx = rs2_idx;
		issue_nxt.rs1_val = rs1_data;
		issue_nxt.rs2_val = rs2_data;
		issue_nxt.dest    = (ctrl.dest_sel == DEST_RD) ? inst.r.rd : `ZERO_REG;
		issue_nxt.imm     = imm;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			issue.ctrl.valid   <= `FALSE;
			issue.ctrl.illegal <= `FALSE;
		end else begin
			issue <= issue_nxt;
		end
	end

endmodule

//--- decode/rv_decoder.sv
`include "rv_consts.svh"

module rv_decoder import rv_pkg::*; (
	input  fetch_pkt_t fetch,
	output ctrl_t      ctrl
);

	inst_t inst;

	assign inst = fetch.inst;

	// funct3 to base op, alt picks sub / arithmetic shift
	function automatic alu_func_e base_func(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? SUB : ADD;
			3'b001:  return SLL;
			3'b010:  return SLT;
			3'b011:  return SLTU;
			3'b100:  return XOR;
			3'b101:  return alt ? SRA : SRL;
			3'b110:  return OR;
			default: return AND;
		endcase
	endfunction

	always_comb begin
		// noop defaults
		ctrl.opa_sel       = OPA_IS_RS1;
		ctrl.opb_sel       = OPB_IS_RS2;
		ctrl.dest_sel      = DEST_NONE;
		ctrl.alu_func      = ADD;
		ctrl.rd_mem        = `FALSE;
		ctrl.wr_mem        = `FALSE;
		ctrl.cond_branch   = `FALSE;
		ctrl.uncond_branch = `FALSE;
		ctrl.csr_op        = `FALSE;
		ctrl.halt          = `FALSE;
		ctrl.illegal       = `FALSE;
		if (fetch.valid) begin
			casez (inst.raw)
				`RV32_LUI, `RV32_AUIPC: begin
					ctrl.dest_sel = DEST_RD;
					ctrl.opa_sel  = inst.r.opcode[5] ? OPA_IS_ZERO : OPA_IS_PC;
					ctrl.opb_sel  = OPB_IS_U_IMM;
				end
				`RV32_JAL: begin
					ctrl.dest_sel      = DEST_RD;
					ctrl.opa_sel       = OPA_IS_PC;
					ctrl.opb_sel       = OPB_IS_J_IMM;
					ctrl.uncond_branch = `TRUE;
				end
				`RV32_JALR: begin
					ctrl.dest_sel      = DEST_RD;
					ctrl.opb_sel       = OPB_IS_I_IMM;
					ctrl.uncond_branch = `TRUE;
				end
				`RV32_BEQ, `RV32_BNE, `RV32_BLT, `RV32_BGE, `RV32_BLTU, `RV32_BGEU: begin
					ctrl.opa_sel     = OPA_IS_PC;
					ctrl.opb_sel     = OPB_IS_B_IMM;
					ctrl.cond_branch = `TRUE;
				end
				`RV32_LB, `RV32_LH, `RV32_LW, `RV32_LBU, `RV32_LHU: begin
					ctrl.opb_sel = OPB_IS_I_IMM;   // address only, no rd write here
					ctrl.rd_mem  = `TRUE;
				end
				`RV32_SB, `RV32_SH, `RV32_SW: begin
					ctrl.opb_sel = OPB_IS_S_IMM;
					ctrl.wr_mem  = `TRUE;
				end
				`RV32_ADDI, `RV32_SLTI, `RV32_SLTIU, `RV32_XORI, `RV32_ORI, `RV32_ANDI,
				`RV32_SLLI, `RV32_SRLI, `RV32_SRAI: begin
					ctrl.dest_sel = DEST_RD;
					ctrl.opb_sel  = OPB_IS_I_IMM;
					// bit 30 only means SRA for the shift-right immediate
					ctrl.alu_func = base_func(inst.r.funct3,
						(inst.r.funct3 == 3'b101) && inst.r.funct7[5]);
				end
				`RV32_ADD, `RV32_SUB, `RV32_SLL, `RV32_SLT, `RV32_SLTU, `RV32_XOR,
				`RV32_SRL, `RV32_SRA, `RV32_OR, `RV32_AND: begin
					ctrl.dest_sel = DEST_RD;
					ctrl.alu_func = base_func(inst.r.funct3, inst.r.funct7[5]);
				end
				`RV32_MUL, `RV32_MULH, `RV32_MULHSU, `RV32_MULHU: begin
					ctrl.dest_sel = DEST_RD;
					case (inst.r.funct3[1:0])
						2'b00:   ctrl.alu_func = MUL;
						2'b01:   ctrl.alu_func = MULH;
						2'b10:   ctrl.alu_func = MULHSU;
						default: ctrl.alu_func = MULHU;
					endcase
				end
				`RV32_CSRRW, `RV32_CSRRS, `RV32_CSRRC: ctrl.csr_op = `TRUE;
				`WFI:    ctrl.halt    = `TRUE;
				default: ctrl.illegal = `TRUE;
			endcase
		end
		ctrl.valid = fetch.valid && !ctrl.illegal;
	end

endmodule

//--- design/regfile.sv
`include "rv_consts.svh"

module regfile import rv_pkg::*; (
	input  logic     clock,
	input  reg_idx_t rda_idx,
	input  reg_idx_t rdb_idx,
	output word_t    rda_out,
	output word_t    rdb_out,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data
);

	word_t mem [`NUM_REGS];

	always_ff @(posedge clock) begin
		if (wr_en && wr_idx != `ZERO_REG)
			mem[wr_idx] <= wr_data;
	end

	// x0 first, then same-cycle write, then the array
	assign rda_out = (rda_idx == `ZERO_REG) ? '0 :
		(wr_en && wr_idx == rda_idx) ? wr_data : mem[rda_idx];
	assign rdb_out = (rdb_idx == `ZERO_REG) ? '0 :
		(wr_en && wr_idx == rdb_idx) ? wr_data : mem[rdb_idx];

endmodule

//--- common/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [4:0]       reg_idx_t;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} r;
	} inst_t;

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} alu_opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM, OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
	} alu_opb_sel_e;

	typedef enum logic {DEST_NONE, DEST_RD} dest_sel_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA, MUL, MULH, MULHSU, MULHU
	} alu_func_e;

	typedef struct packed {
		logic  valid;
		inst_t inst;
		addr_t pc;
	} fetch_pkt_t;

	typedef struct packed {
		alu_opa_sel_e opa_sel;
		alu_opb_sel_e opb_sel;
		dest_sel_e    dest_sel;
		alu_func_e    alu_func;
		logic         rd_mem;
		logic         wr_mem;
		logic         cond_branch;
		logic         uncond_branch;
		logic         csr_op;
		logic         halt;
		logic         illegal;
		logic         valid;   // fetch valid and not illegal
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		addr_t    pc;
		reg_idx_t rs1_idx;
		reg_idx_t rs2_idx;
		word_t    rs1_val;
		word_t    rs2_val;
		reg_idx_t dest;   // x0 when nothing is written
		word_t    imm;
	} issue_pkt_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		word_t    result;   // link value for jumps
		addr_t    target;
		logic     cond_branch;
		logic     uncond_branch;
		logic     rd_mem;
		logic     wr_mem;
		logic     csr_op;
		logic     halt;
		logic     illegal;
	} exec_pkt_t;

	typedef exec_pkt_t retire_pkt_t;

endpackage

//--- common/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN      32
`define NUM_REGS  32
`define ZERO_REG  5'd0
`define TRUE      1'b1
`define FALSE     1'b0

// fields: funct7 _ rs2 _ rs1 _ funct3 _ rd _ opcode
`define RV32_LUI    32'b????????????????????_?????_0110111
`define RV32_AUIPC  32'b????????????????????_?????_0010111
`define RV32_JAL    32'b????????????????????_?????_1101111
`define RV32_JALR   32'b???????_?????_?????_000_?????_1100111
`define RV32_BEQ    32'b???????_?????_?????_000_?????_1100011
`define RV32_BNE    32'b???????_?????_?????_001_?????_1100011
`define RV32_BLT    32'b???????_?????_?????_100_?????_1100011
`define RV32_BGE    32'b???????_?????_?????_101_?????_1100011
`define RV32_BLTU   32'b???????_?????_?????_110_?????_1100011
`define RV32_BGEU   32'b???????_?????_?????_111_?????_1100011
`define RV32_LB     32'b???????_?????_?????_000_?????_0000011
`define RV32_LH     32'b???????_?????_?????_001_?????_0000011
`define RV32_LW     32'b???????_?????_?????_010_?????_0000011
`define RV32_LBU    32'b???????_?????_?????_100_?????_0000011
`define RV32_LHU    32'b???????_?????_?????_101_?????_0000011
`define RV32_SB     32'b???????_?????_?????_000_?????_0100011
`define RV32_SH     32'b???????_?????_?????_001_?????_0100011
`define RV32_SW     32'b???????_?????_?????_010_?????_0100011
`define RV32_ADDI   32'b???????_?????_?????_000_?????_0010011
`define RV32_SLTI   32'b???????_?????_?????_010_?????_0010011
`define RV32_SLTIU  32'b???????_?????_?????_011_?????_0010011
`define RV32_XORI   32'b???????_?????_?????_100_?????_0010011
`define RV32_ORI    32'b???????_?????_?????_110_?????_0010011
`define RV32_ANDI   32'b???????_?????_?????_111_?????_0010011
`define RV32_SLLI   32'b0000000_?????_?????_001_?????_0010011
`define RV32_SRLI   32'b0000000_?????_?????_101_?????_0010011
`define RV32_SRAI   32'b0100000_?????_?????_101_?????_0010011
`define RV32_ADD    32'b0000000_?????_?????_000_?????_0110011
`define RV32_SUB    32'b0100000_?????_?????_000_?????_0110011
`define RV32_SLL    32'b0000000_?????_?????_001_?????_0110011
`define RV32_SLT    32'b0000000_?????_?????_010_?????_0110011
`define RV32_SLTU   32'b0000000_?????_?????_011_?????_0110011
`define RV32_XOR    32'b0000000_?????_?????_100_?????_0110011
`define RV32_SRL    32'b0000000_?????_?????_101_?????_0110011
`define RV32_SRA    32'b0100000_?????_?????_101_?????_0110011
`define RV32_OR     32'b0000000_?????_?????_110_?????_0110011
`define RV32_AND    32'b0000000_?????_?????_111_?????_0110011
`define RV32_MUL    32'b0000001_?????_?????_000_?????_0110011
`define RV32_MULH   32'b0000001_?????_?????_001_?????_0110011
`define RV32_MULHSU 32'b0000001_?????_?????_010_?????_0110011
`define RV32_MULHU  32'b0000001_?????_?????_011_?????_0110011
`define RV32_CSRRW  32'b???????_?????_?????_001_?????_1110011
`define RV32_CSRRS  32'b???????_?????_?????_010_?????_1110011
`define RV32_CSRRC  32'b???????_?????_?????_011_?????_1110011
`define WFI         32'b0001000_00101_00000_000_00000_1110011

`endif
